/* source/board_pkg.sv */
`default_nettype none

package board_pkg;

	// Play field size in cells
	localparam int FIELD_W = 10;
	localparam int FIELD_H = 20;

	// Field placement inside board memory
	localparam int X_ORIGIN = 10;
	localparam int Y_ORIGIN = 5;

	localparam int ROW_W = 5;
	localparam int COL_W = 6;
	localparam int ADDR_W = ROW_W + COL_W;

	typedef logic [ROW_W-1:0] row_t;
	typedef logic [COL_W-1:0] col_t;

	// Zero is empty, 1 to 7 is the kind that filled the cell
	typedef logic [5:0] cell_t;

	typedef struct packed {
		row_t row;
		col_t col;
	} board_rc_t;

	// Same word seen as flat memory index or as row and column
	typedef union packed {
		logic [ADDR_W-1:0] index;
		board_rc_t rc;
	} board_addr_u;

	typedef struct packed {
		logic valid;
		logic write;
		board_addr_u addr;
		cell_t data;
	} board_req_t;

	// Field-relative cell to board address
	function automatic board_addr_u field_addr(row_t row, col_t col);
		board_addr_u a;
		a.rc.row = row + row_t'(Y_ORIGIN);
		a.rc.col = col + col_t'(X_ORIGIN);
		return a;
	endfunction

endpackage

`default_nettype wire

/* source/piece_pkg.sv */
`default_nettype none

package piece_pkg;

	localparam int KIND_W = 3;
	localparam int NUM_KINDS = 7;

	typedef logic [KIND_W-1:0] kind_t;

	typedef struct packed {
		logic [1:0] row;
		logic [1:0] col;
	} offset_t;

	// One fixed orientation per kind, four cells each
	// Line, square, L, J, S, Z, T
	localparam offset_t SHAPES [1:NUM_KINDS][4] = '{
		'{'{2'd0, 2'd0}, '{2'd0, 2'd1}, '{2'd0, 2'd2}, '{2'd0, 2'd3}},
		'{'{2'd0, 2'd0}, '{2'd0, 2'd1}, '{2'd1, 2'd0}, '{2'd1, 2'd1}},
		'{'{2'd0, 2'd0}, '{2'd1, 2'd0}, '{2'd2, 2'd0}, '{2'd2, 2'd1}},
		'{'{2'd0, 2'd1}, '{2'd1, 2'd1}, '{2'd2, 2'd1}, '{2'd2, 2'd0}},
		'{'{2'd0, 2'd1}, '{2'd0, 2'd2}, '{2'd1, 2'd0}, '{2'd1, 2'd1}},
		'{'{2'd0, 2'd0}, '{2'd0, 2'd1}, '{2'd1, 2'd1}, '{2'd1, 2'd2}},
		'{'{2'd0, 2'd0}, '{2'd0, 2'd1}, '{2'd0, 2'd2}, '{2'd1, 2'd1}}
	};

	// Position of the shape's top left corner, field relative
	typedef struct packed {
		kind_t kind;
		board_pkg::row_t row;
		board_pkg::col_t col;
	} piece_t;

	typedef enum logic [1:0] {DIR_DOWN, DIR_LEFT, DIR_RIGHT} dir_e;

	// Board address of cell i of a piece
	function automatic board_pkg::board_addr_u cell_addr(piece_t p, logic [1:0] i);
		offset_t off;
		off = SHAPES[p.kind][i];
		return board_pkg::field_addr(p.row + board_pkg::row_t'(off.row),
			p.col + board_pkg::col_t'(off.col));
	endfunction

endpackage

`default_nettype wire

/* source/board_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module board_arbiter
(
	input logic clk,
	input logic reset,
	input board_pkg::board_req_t chk_req,
	input board_pkg::board_req_t pnt_req,
	input board_pkg::board_req_t clr_req,
	output logic chk_grant,
	output logic pnt_grant,
	output logic clr_grant,
	output logic chk_rd_valid,
	output logic pnt_rd_valid,
	output logic clr_rd_valid,
	output board_pkg::board_req_t board_req
);

	// Owner of last cycle's read, one bit per requester
	logic [2:0] rd_owner;

	// Fixed priority, clearer first
	always_comb
	begin
		clr_grant = clr_req.valid;
		pnt_grant = pnt_req.valid && !clr_req.valid;
		chk_grant = chk_req.valid && !clr_req.valid && !pnt_req.valid;
		board_req = '0;
		if (clr_grant)
			board_req = clr_req;
		else if (pnt_grant)
			board_req = pnt_req;
		else if (chk_grant)
			board_req = chk_req;
	end

	// Memory answers one cycle later
	always_ff @(posedge clk)
	begin
		if (reset)
			rd_owner <= '0;
		else
			rd_owner <= {clr_grant && !clr_req.write, pnt_grant && !pnt_req.write,
				chk_grant && !chk_req.write};
	end

	assign clr_rd_valid = rd_owner[2];
	assign pnt_rd_valid = rd_owner[1];
	assign chk_rd_valid = rd_owner[0];

endmodule

`default_nettype wire

/* source/collision_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module collision_checker
(
	input logic clk,
	input logic reset,
	input logic start,
	input piece_pkg::piece_t piece,
	input piece_pkg::dir_e dir,
	output board_pkg::board_req_t req,
	input logic grant,
	input logic rd_valid,
	input board_pkg::cell_t rd_data,
	output logic done,
	output logic ok
);

	typedef enum logic [1:0] {C_IDLE, C_CHECK, C_READ, C_WAIT} chk_state_e;

	chk_state_e state;
	logic [1:0] idx;
	piece_pkg::piece_t cur_piece;
	piece_pkg::dir_e cur_dir;

	// Shifted cell, column biased by one so left of the wall is zero
	piece_pkg::offset_t off;
	logic [board_pkg::ROW_W:0] srow;
	logic [board_pkg::COL_W:0] scol;
	logic outside;
	logic own;

	always_comb
	begin
		off = piece_pkg::SHAPES[cur_piece.kind][idx];
		srow = {1'b0, cur_piece.row} + off.row;
		scol = {1'b0, cur_piece.col} + off.col + 1'b1;
		if (cur_dir == piece_pkg::DIR_DOWN)
			srow = srow + 1'b1;
		else if (cur_dir == piece_pkg::DIR_LEFT)
			scol = scol - 1'b1;
		else
			scol = scol + 1'b1;
		outside = (srow >= board_pkg::FIELD_H) || (scol == '0) || (scol > board_pkg::FIELD_W);
		// A cell the piece already covers does not block it
		own = 1'b0;
		for (int j = 0; j < 4; j++)
		begin
			if (({1'b0, cur_piece.row} + piece_pkg::SHAPES[cur_piece.kind][j].row == srow) &&
				({1'b0, cur_piece.col} + piece_pkg::SHAPES[cur_piece.kind][j].col + 1'b1 == scol))
				own = 1'b1;
		end
	end

	always_comb
	begin
		req = '0;
		req.valid = (state == C_READ);
		req.addr = board_pkg::field_addr(srow[board_pkg::ROW_W-1:0],
			board_pkg::col_t'(scol - 1'b1));
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= C_IDLE;
			idx <= '0;
			done <= 1'b0;
			ok <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				C_IDLE:
					if (start)
					begin
						idx <= '0;
						state <= C_CHECK;
					end
				C_CHECK:
					// Off the field fails without a read
					if (outside)
					begin
						done <= 1'b1;
						ok <= 1'b0;
						state <= C_IDLE;
					end
					else
						state <= C_READ;
				C_READ:
					if (grant)
						state <= C_WAIT;
				default:
					if (rd_valid)
					begin
						if (rd_data != '0 && !own)
						begin
							done <= 1'b1;
							ok <= 1'b0;
							state <= C_IDLE;
						end
						else if (idx == 2'd3)
						begin
							done <= 1'b1;
							ok <= 1'b1;
							state <= C_IDLE;
						end
						else
						begin
							idx <= idx + 1'b1;
							state <= C_CHECK;
						end
					end
			endcase
		end
	end

	// Command payload
	always_ff @(posedge clk)
	begin
		if (state == C_IDLE && start)
		begin
			cur_piece <= piece;
			cur_dir <= dir;
		end
	end

endmodule

`default_nettype wire

/* source/piece_painter.sv */
`timescale 1ns/100ps
`default_nettype none

module piece_painter
(
	input logic clk,
	input logic reset,
	input logic start,
	input piece_pkg::piece_t piece,
	input board_pkg::cell_t value,
	output board_pkg::board_req_t req,
	input logic grant,
	output logic done
);

	typedef enum logic {P_IDLE, P_WRITE} pnt_state_e;

	pnt_state_e state;
	logic [1:0] idx;
	piece_pkg::piece_t cur_piece;
	board_pkg::cell_t cur_value;

	// One cell write held until granted
	always_comb
	begin
		req = '0;
		if (state == P_WRITE)
		begin
			req.valid = 1'b1;
			req.write = 1'b1;
			req.addr = piece_pkg::cell_addr(cur_piece, idx);
			req.data = cur_value;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= P_IDLE;
			idx <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (state == P_IDLE)
			begin
				if (start)
				begin
					idx <= '0;
					state <= P_WRITE;
				end
			end
			else if (grant)
			begin
				// Fourth cell ends the command
				if (idx == 2'd3)
				begin
					done <= 1'b1;
					state <= P_IDLE;
				end
				idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == P_IDLE && start)
		begin
			cur_piece <= piece;
			cur_value <= value;
		end
	end

endmodule

`default_nettype wire

/* source/row_clearer.sv */
`timescale 1ns/100ps
`default_nettype none

module row_clearer
(
	input logic clk,
	input logic reset,
	input logic start,
	output board_pkg::board_req_t req,
	input logic grant,
	input logic rd_valid,
	input board_pkg::cell_t rd_data,
	output logic done,
	output logic [2:0] lines
);

	typedef enum logic [2:0] {
		R_IDLE, R_SCAN_RD, R_SCAN_WAIT, R_COPY_RD, R_COPY_WAIT, R_COPY_WR
	} clr_state_e;

	clr_state_e state;
	board_pkg::row_t cur_row;
	board_pkg::col_t cur_col;
	board_pkg::row_t first_row;
	logic [2:0] count;
	board_pkg::cell_t hold;

	logic last_col;
	logic last_row;
	logic row_full;
	logic [2:0] scan_cnt;
	board_pkg::row_t scan_first;
	board_pkg::row_t bottom;
	board_pkg::row_t nxt_row;

	////////////////////////////////////////////////////////////////////////////
	// Group bookkeeping at the end of a scanned row
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		last_col = (cur_col == board_pkg::col_t'(board_pkg::FIELD_W - 1));
		last_row = (cur_row == board_pkg::row_t'(board_pkg::FIELD_H - 1));
		// Empty cell ends the row early
		row_full = (rd_data != '0);
		scan_cnt = count;
		scan_first = first_row;
		if (row_full)
		begin
			scan_cnt = count + 1'b1;
			if (count == '0)
				scan_first = cur_row;
		end
		// Lowest row of the group
		bottom = scan_first + board_pkg::row_t'(scan_cnt) - 1'b1;
		nxt_row = last_col ? cur_row - 1'b1 : cur_row;
	end

	always_comb
	begin
		req = '0;
		case (state)
			R_SCAN_RD:
			begin
				req.valid = 1'b1;
				req.addr = board_pkg::field_addr(cur_row, cur_col);
			end
			R_COPY_RD:
			begin
				// Source sits count rows above the target
				req.valid = 1'b1;
				req.addr = board_pkg::field_addr(cur_row - board_pkg::row_t'(count), cur_col);
			end
			R_COPY_WR:
			begin
				req.valid = 1'b1;
				req.write = 1'b1;
				req.addr = board_pkg::field_addr(cur_row, cur_col);
				req.data = hold;
			end
			default:
				req = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Scan top down, then shift bottom up
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= R_IDLE;
			cur_row <= '0;
			cur_col <= '0;
			first_row <= '0;
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				R_IDLE:
					if (start)
					begin
						cur_row <= '0;
						cur_col <= '0;
						first_row <= '0;
						count <= '0;
						state <= R_SCAN_RD;
					end
				R_SCAN_RD:
					if (grant)
						state <= R_SCAN_WAIT;
				R_SCAN_WAIT:
					if (rd_valid)
					begin
						if (row_full && !last_col)
						begin
							cur_col <= cur_col + 1'b1;
							state <= R_SCAN_RD;
						end
						else
						begin
							count <= scan_cnt;
							first_row <= scan_first;
							// Group ends on a gap, at four rows or at the floor
							if (scan_cnt != '0 && (!row_full || scan_cnt == 3'd4 || last_row))
							begin
								cur_row <= bottom;
								cur_col <= '0;
								hold <= '0;
								state <= (bottom >= board_pkg::row_t'(scan_cnt)) ? R_COPY_RD : R_COPY_WR;
							end
							else if (last_row)
							begin
								done <= 1'b1;
								state <= R_IDLE;
							end
							else
							begin
								cur_row <= cur_row + 1'b1;
								cur_col <= '0;
								state <= R_SCAN_RD;
							end
						end
					end
				R_COPY_RD:
					if (grant)
						state <= R_COPY_WAIT;
				R_COPY_WAIT:
					if (rd_valid)
					begin
						hold <= rd_data;
						state <= R_COPY_WR;
					end
				default:
					if (grant)
					begin
						if (last_col && cur_row == '0)
						begin
							done <= 1'b1;
							state <= R_IDLE;
						end
						else
						begin
							cur_row <= nxt_row;
							cur_col <= last_col ? '0 : cur_col + 1'b1;
							// Top rows get zeros without a read
							hold <= '0;
							state <= (nxt_row >= board_pkg::row_t'(count)) ? R_COPY_RD : R_COPY_WR;
						end
					end
			endcase
		end
	end

	assign lines = count;

endmodule

`default_nettype wire

/* source/game_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module game_sequencer
#(
	parameter int GRAVITY_FRAMES = 20,
	parameter int SPAWN_COL = 3
)
(
	input logic clk,
	input logic reset,
	input logic frame_tick,
	input logic btn_left,
	input logic btn_right,
	output logic chk_start,
	output piece_pkg::piece_t chk_piece,
	output piece_pkg::dir_e chk_dir,
	input logic chk_done,
	input logic chk_ok,
	output logic pnt_start,
	output piece_pkg::piece_t pnt_piece,
	output board_pkg::cell_t pnt_value,
	input logic pnt_done,
	output logic clr_start,
	input logic clr_done,
	input logic [2:0] clr_lines,
	output logic [14:0] score,
	output logic [2:0] lines_last,
	output logic busy
);

	localparam int GW = $clog2(GRAVITY_FRAMES + 1);

	typedef enum logic [2:0] {
		Q_IDLE, Q_DECIDE, Q_CHK_W, Q_ERASE_W, Q_DRAW, Q_DRAW_W, Q_CLEAR_W
	} seq_state_e;

	seq_state_e state;
	piece_pkg::piece_t piece;
	piece_pkg::piece_t moved;
	piece_pkg::piece_t spawn;
	piece_pkg::dir_e cur_dir;
	piece_pkg::dir_e side_dir;
	logic want_down;
	logic want_side;
	logic [GW-1:0] grav_cnt;
	board_pkg::cell_t value;

	assign chk_piece = piece;
	assign chk_dir = cur_dir;
	assign pnt_piece = piece;
	assign pnt_value = value;

	always_comb
	begin
		moved = piece;
		case (cur_dir)
			piece_pkg::DIR_DOWN: moved.row = piece.row + 1'b1;
			piece_pkg::DIR_LEFT: moved.col = piece.col - 1'b1;
			default: moved.col = piece.col + 1'b1;
		endcase
		// Kinds taken in turn with 7 wrapping to 1
		spawn = '0;
		spawn.col = board_pkg::col_t'(SPAWN_COL);
		if (piece.kind == piece_pkg::kind_t'(piece_pkg::NUM_KINDS))
			spawn.kind = piece_pkg::kind_t'(1);
		else
			spawn.kind = piece.kind + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// First kind is drawn right out of reset
			state <= Q_DRAW;
			piece <= '0;
			piece.kind <= piece_pkg::kind_t'(1);
			piece.col <= board_pkg::col_t'(SPAWN_COL);
			cur_dir <= piece_pkg::DIR_DOWN;
			want_down <= 1'b0;
			want_side <= 1'b0;
			grav_cnt <= '0;
			busy <= 1'b0;
			score <= '0;
			lines_last <= '0;
			chk_start <= 1'b0;
			pnt_start <= 1'b0;
			clr_start <= 1'b0;
		end
		else
		begin
			chk_start <= 1'b0;
			pnt_start <= 1'b0;
			clr_start <= 1'b0;
			case (state)
				Q_IDLE:
					if (frame_tick)
					begin
						busy <= 1'b1;
						state <= Q_DECIDE;
						if (grav_cnt == GW'(GRAVITY_FRAMES - 1))
						begin
							grav_cnt <= '0;
							want_down <= 1'b1;
						end
						else
							grav_cnt <= grav_cnt + 1'b1;
						// Left wins over right
						want_side <= btn_left || btn_right;
						side_dir <= btn_left ? piece_pkg::DIR_LEFT : piece_pkg::DIR_RIGHT;
					end
				Q_DECIDE:
					if (want_down)
					begin
						want_down <= 1'b0;
						cur_dir <= piece_pkg::DIR_DOWN;
						chk_start <= 1'b1;
						state <= Q_CHK_W;
					end
					else if (want_side)
					begin
						want_side <= 1'b0;
						cur_dir <= side_dir;
						chk_start <= 1'b1;
						state <= Q_CHK_W;
					end
					else
					begin
						busy <= 1'b0;
						state <= Q_IDLE;
					end
				Q_CHK_W:
					if (chk_done)
					begin
						if (chk_ok)
						begin
							// Erase at the old cells first
							value <= '0;
							pnt_start <= 1'b1;
							state <= Q_ERASE_W;
						end
						else if (cur_dir == piece_pkg::DIR_DOWN)
						begin
							// Landed so no side move this frame
							want_side <= 1'b0;
							clr_start <= 1'b1;
							state <= Q_CLEAR_W;
						end
						else
							state <= Q_DECIDE;
					end
				Q_ERASE_W:
					if (pnt_done)
					begin
						piece <= moved;
						state <= Q_DRAW;
					end
				Q_DRAW:
				begin
					// Spawn out of reset counts as busy too
					busy <= 1'b1;
					value <= board_pkg::cell_t'(piece.kind);
					pnt_start <= 1'b1;
					state <= Q_DRAW_W;
				end
				Q_DRAW_W:
					if (pnt_done)
						state <= Q_DECIDE;
				default:
					if (clr_done)
					begin
						// Four lines score double
						score <= score + ((clr_lines == 3'd4) ? 15'd8 : 15'(clr_lines));
						lines_last <= clr_lines;
						piece <= spawn;
						state <= Q_DRAW;
					end
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/tetris_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tetris_core
#(
	parameter int GRAVITY_FRAMES = 20,
	parameter int SPAWN_COL = 3
)
(
	input logic clk,
	input logic reset,
	input logic frame_tick,
	input logic btn_left,
	input logic btn_right,
	input board_pkg::cell_t board_rd_data,
	output board_pkg::board_req_t board_req,
	output logic [14:0] score,
	output logic [2:0] lines_last,
	output logic busy
);

	////////////////////////////////////////////////////////////////////////////
	// Board port sharing
	////////////////////////////////////////////////////////////////////////////

	board_pkg::board_req_t chk_req;
	board_pkg::board_req_t pnt_req;
	board_pkg::board_req_t clr_req;
	logic chk_grant;
	logic pnt_grant;
	logic clr_grant;
	logic chk_rd_valid;
	logic pnt_rd_valid;
	logic clr_rd_valid;

	// Sequencer commands
	logic chk_start;
	logic chk_done;
	logic chk_ok;
	piece_pkg::piece_t chk_piece;
	piece_pkg::dir_e chk_dir;
	logic pnt_start;
	logic pnt_done;
	piece_pkg::piece_t pnt_piece;
	board_pkg::cell_t pnt_value;
	logic clr_start;
	logic clr_done;
	logic [2:0] clr_lines;

	board_arbiter arb0 (
		.clk, .reset, .chk_req, .pnt_req, .clr_req, .chk_grant, .pnt_grant, .clr_grant,
		.chk_rd_valid, .pnt_rd_valid, .clr_rd_valid, .board_req
	);

	collision_checker chk0 (
		.clk, .reset, .start(chk_start), .piece(chk_piece), .dir(chk_dir), .req(chk_req),
		.grant(chk_grant), .rd_valid(chk_rd_valid), .rd_data(board_rd_data),
		.done(chk_done), .ok(chk_ok)
	);

	piece_painter pnt0 (
		.clk, .reset, .start(pnt_start), .piece(pnt_piece), .value(pnt_value),
		.req(pnt_req), .grant(pnt_grant), .done(pnt_done)
	);

	row_clearer clr0 (
		.clk, .reset, .start(clr_start), .req(clr_req), .grant(clr_grant),
		.rd_valid(clr_rd_valid), .rd_data(board_rd_data), .done(clr_done), .lines(clr_lines)
	);

	game_sequencer #(
		.GRAVITY_FRAMES(GRAVITY_FRAMES),
		.SPAWN_COL(SPAWN_COL)
	) seq0 (
		.clk, .reset, .frame_tick, .btn_left, .btn_right,
		.chk_start, .chk_piece, .chk_dir, .chk_done, .chk_ok,
		.pnt_start, .pnt_piece, .pnt_value, .pnt_done,
		.clr_start, .clr_done, .clr_lines, .score, .lines_last, .busy
	);

endmodule

`default_nettype wire

/* dv/tetris_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module tetris_properties
(
	input logic clk,
	input logic reset,
	input board_pkg::board_req_t board_req,
	input logic chk_grant,
	input logic pnt_grant,
	input logic clr_grant,
	input logic [14:0] score
);

	// Failures so far, read back by the testbench
	int fail_count = 0;

	logic in_field;

	// Field window in board memory
	always_comb
	begin
		in_field = (board_req.addr.rc.row >= board_pkg::row_t'(board_pkg::Y_ORIGIN)) &&
			(board_req.addr.rc.row < board_pkg::row_t'(board_pkg::Y_ORIGIN + board_pkg::FIELD_H)) &&
			(board_req.addr.rc.col >= board_pkg::col_t'(board_pkg::X_ORIGIN)) &&
			(board_req.addr.rc.col < board_pkg::col_t'(board_pkg::X_ORIGIN + board_pkg::FIELD_W));
	end

	////////////////////////////////////////////////////////////////////////////
	// Board port rules
	////////////////////////////////////////////////////////////////////////////

	// Zeros may land anywhere, piece cells only inside the field
	nonzero_write_in_field: assert property (@(posedge clk) disable iff (reset)
		(board_req.valid && board_req.write && board_req.data != '0) |-> in_field)
	else
	begin
		fail_count++;
		$error("nonzero board write outside the field");
	end

	// One owner per access
	valid_one_grant: assert property (@(posedge clk) disable iff (reset)
		board_req.valid |-> $onehot({chk_grant, pnt_grant, clr_grant}))
	else
	begin
		fail_count++;
		$error("board access without exactly one grant");
	end

	score_monotonic: assert property (@(posedge clk) disable iff (reset)
		score >= $past(score))
	else
	begin
		fail_count++;
		$error("score went down");
	end

endmodule

`default_nettype wire

/* dv/tb_tetris.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tetris;

	localparam int NUM_FRAMES = 300;
	localparam int SPAWN_COL = 3;

	logic clk;
	logic reset;
	logic frame_tick;
	logic btn_left;
	logic btn_right;
	board_pkg::cell_t board_rd_data = '0;
	board_pkg::board_req_t board_req;
	logic [14:0] score;
	logic [2:0] lines_last;
	logic busy;

	// Whole 11-bit board memory
	board_pkg::cell_t mem [0:2047];

	// Writes seen on the port and writes the model predicts
	logic [16:0] got_q [$];
	logic [16:0] exp_q [$];

	// Shadow field and piece
	int brd [0:19][0:9];
	int p_kind;
	int p_row;
	int p_col;
	int frames;
	int exp_score;
	int exp_lines;
	bit landed;
	bit cleared;
	int checks;
	int errors;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	tetris_core #(.GRAVITY_FRAMES(2), .SPAWN_COL(SPAWN_COL)) dut0 (
		.clk, .reset, .frame_tick, .btn_left, .btn_right, .board_rd_data,
		.board_req, .score, .lines_last, .busy
	);

	bind tetris_core tetris_properties props0 (
		.clk, .reset, .board_req, .chk_grant, .pnt_grant, .clr_grant, .score
	);

	////////////////////////////////////////////////////////////////////////////
	// Board contents and memory model
	////////////////////////////////////////////////////////////////////////////

	// Bottom row full but for columns 0 to 3 and two cells in the row above
	function automatic board_pkg::cell_t preload(int r, int c);
		if (r == 19 && c >= 4)
			return 6'd3;
		if (r == 18 && (c == 5 || c == 6))
			return 6'd2;
		return '0;
	endfunction

	function automatic board_pkg::cell_t start_cell(int i);
		int r;
		int c;
		r = i / 64 - board_pkg::Y_ORIGIN;
		c = i % 64 - board_pkg::X_ORIGIN;
		if (r >= 0 && r < board_pkg::FIELD_H && c >= 0 && c < board_pkg::FIELD_W)
			return preload(r, c);
		return '0;
	endfunction

	function automatic logic [10:0] addr_of(int r, int c);
		return 11'(((r + board_pkg::Y_ORIGIN) << board_pkg::COL_W) + c + board_pkg::X_ORIGIN);
	endfunction

	// One cycle read latency with writes recorded in order
	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2048; i++)
				mem[i] <= start_cell(i);
			board_rd_data <= '0;
		end
		else if (board_req.valid)
		begin
			if (board_req.write)
			begin
				mem[board_req.addr.index] <= board_req.data;
				got_q.push_back({board_req.addr.index, board_req.data});
			end
			else
				board_rd_data <= mem[board_req.addr.index];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shadow piece model
	////////////////////////////////////////////////////////////////////////////

	function automatic bit own_cell(int r, int c);
		for (int i = 0; i < 4; i++)
			if (p_row + piece_pkg::SHAPES[p_kind][i].row == r &&
				p_col + piece_pkg::SHAPES[p_kind][i].col == c)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic bit fits(int dr, int dc);
		int r;
		int c;
		for (int i = 0; i < 4; i++)
		begin
			r = p_row + piece_pkg::SHAPES[p_kind][i].row + dr;
			c = p_col + piece_pkg::SHAPES[p_kind][i].col + dc;
			if (r < 0 || r >= board_pkg::FIELD_H || c < 0 || c >= board_pkg::FIELD_W)
				return 1'b0;
			if (brd[r][c] != 0 && !own_cell(r, c))
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// Four cell writes in shape order
	task automatic paint(int value);
		int r;
		int c;
		for (int i = 0; i < 4; i++)
		begin
			r = p_row + piece_pkg::SHAPES[p_kind][i].row;
			c = p_col + piece_pkg::SHAPES[p_kind][i].col;
			brd[r][c] = value;
			exp_q.push_back({addr_of(r, c), 6'(value)});
		end
	endtask

	task automatic try_move(int dr, int dc, output bit moved);
		moved = fits(dr, dc);
		if (moved)
		begin
			paint(0);
			p_row += dr;
			p_col += dc;
			paint(p_kind);
		end
	endtask

	// First group of up to four full rows drops out
	function automatic int clear_rows();
		int first;
		int n;
		bit full;
		first = -1;
		n = 0;
		for (int r = 0; r < board_pkg::FIELD_H; r++)
		begin
			full = 1'b1;
			for (int c = 0; c < board_pkg::FIELD_W; c++)
				if (brd[r][c] == 0)
					full = 1'b0;
			if (full && n < 4)
			begin
				if (n == 0)
					first = r;
				n++;
			end
			else if (n > 0)
				break;
		end
		if (n > 0)
			for (int r = first + n - 1; r >= 0; r--)
				for (int c = 0; c < board_pkg::FIELD_W; c++)
					brd[r][c] = (r >= n) ? brd[r-n][c] : 0;
		return n;
	endfunction

	task automatic predict_frame(bit left, bit right);
		bit moved;
		frames++;
		landed = 1'b0;
		cleared = 1'b0;
		exp_q.delete();
		if (frames % 2 == 0)
		begin
			try_move(1, 0, moved);
			landed = !moved;
		end
		if (!landed && (left || right))
			try_move(0, left ? -1 : 1, moved);
		// Landed piece stays while rows clear and the next kind spawns
		if (landed)
		begin
			exp_lines = clear_rows();
			cleared = (exp_lines != 0);
			exp_score += (exp_lines == 4) ? 8 : exp_lines;
			p_kind = (p_kind % piece_pkg::NUM_KINDS) + 1;
			p_row = 0;
			p_col = SPAWN_COL;
			paint(p_kind);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic expect_equal(string name, int expected, int actual);
		checks++;
		assert (expected == actual)
		else
		begin
			errors++;
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Clear frames write many cells first so only the tail is predicted
	task automatic match_writes(string name, int base);
		int n;
		n = got_q.size() - base;
		if (n < exp_q.size() || (!cleared && n != exp_q.size()))
			expect_equal({name, " write count"}, exp_q.size(), n);
		else
			for (int k = 0; k < exp_q.size(); k++)
				expect_equal({name, " write"}, exp_q[k], got_q[base + n - exp_q.size() + k]);
	endtask

	task automatic verify_field(string name);
		for (int r = 0; r < board_pkg::FIELD_H; r++)
			for (int c = 0; c < board_pkg::FIELD_W; c++)
				expect_equal({name, " field"}, brd[r][c], mem[addr_of(r, c)]);
	endtask

	// One tick per frame while idle, busy must rise on the next cycle
	task automatic run_frame(string name, bit left, bit right);
		int base;
		@(negedge clk);
		while (busy)
			@(negedge clk);
		base = got_q.size();
		@(posedge clk);
		frame_tick <= 1'b1;
		btn_left <= left;
		btn_right <= right;
		@(posedge clk);
		frame_tick <= 1'b0;
		@(negedge clk);
		checks++;
		assert (busy)
		else
		begin
			errors++;
			$display("Frame tick in %s left the engine idle instead of busy", name);
		end
		predict_frame(left, right);
		while (busy)
			@(negedge clk);
		match_writes(name, base);
		verify_field(name);
		expect_equal({name, " score"}, exp_score, score);
		expect_equal({name, " lines_last"}, exp_lines, lines_last);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int rnd;
		void'($urandom(32'hf5a3));
		reset = 1'b1;
		frame_tick = 1'b0;
		btn_left = 1'b0;
		btn_right = 1'b0;
		checks = 0;
		errors = 0;
		frames = 0;
		exp_score = 0;
		exp_lines = 0;
		landed = 1'b0;
		cleared = 1'b0;
		p_kind = 1;
		p_row = 0;
		p_col = SPAWN_COL;
		for (int r = 0; r < board_pkg::FIELD_H; r++)
			for (int c = 0; c < board_pkg::FIELD_W; c++)
				brd[r][c] = preload(r, c);
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Kind 1 drawn right out of reset
		exp_q.delete();
		paint(1);
		@(negedge clk);
		while (got_q.size() < 4)
			@(negedge clk);
		match_writes("spawn", 0);

		// Line to the left wall and then down onto the bottom row
		while (!landed && frames < NUM_FRAMES)
			run_frame("left_wall", 1'b1, 1'b0);
		expect_equal("row_clear score", 1, score);
		expect_equal("row_clear lines_last", 1, lines_last);
		for (int c = 0; c < board_pkg::FIELD_W; c++)
		begin
			expect_equal("row_clear bottom", preload(18, c), mem[addr_of(19, c)]);
			if (!own_cell(0, c))
				expect_equal("row_clear top", 0, mem[addr_of(0, c)]);
		end

		for (int i = 0; i < 12; i++)
			run_frame("right_wall", 1'b0, 1'b1);

		// Bit 0 is left and bit 1 is right with left winning when both are set
		while (frames < NUM_FRAMES)
		begin
			rnd = $urandom % 4;
			run_frame("random", rnd[0], rnd[1]);
		end

		$display("Frames: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
			frames, checks, errors, dut0.props0.fail_count);
		if (errors == 0 && dut0.props0.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Far longer than the slowest frame with a clear
	initial
	begin
		#(NUM_FRAMES * 2000 * 20);
		$display("Watchdog expired, the engine stopped finishing its frames");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
source/board_pkg.sv
source/piece_pkg.sv
source/board_arbiter.sv
source/collision_checker.sv
source/piece_painter.sv
source/row_clearer.sv
source/game_sequencer.sv
source/tetris_core.sv
dv/tetris_properties.sv
dv/tb_tetris.sv

/* Makefile */
# Verilator build and run of the tetris engine testbench

TOP = tb_tetris

all: run

obj_dir/V$(TOP): sim.f $(wildcard source/*.sv dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	@! grep -qF '*** FAILED ***' sim.log
	@grep -qF '*** PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
